//--- Makefile
# Verilator build for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_hack_memory
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(shell cat $(FLIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# the log decides the result, the simulator status alone is not enough
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not succeed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
logic/hack_mem_pkg.sv
logic/word_ram.sv
logic/memory_map.sv
logic/screen_arbiter.sv
logic/video_scanner.sv
logic/hack_memory_top.sv
sim/hack_memory_assert.sv
sim/tb_hack_memory.sv

//--- logic/hack_mem_pkg.sv
package hack_mem_pkg;

    // word and address widths
    localparam int DATA_W        = 16;
    localparam int CPU_ADDR_W    = 15;
    localparam int SCREEN_ADDR_W = 13;

    // address map in words
    localparam int RAM_WORDS     = 16384;
    localparam int SCREEN_BASE   = 16384;
    localparam int SCREEN_WORDS  = 8192;
    localparam int KBD_ADDR      = 24576;

    // raster geometry, one bit per pixel
    localparam int SCREEN_COLS   = 512;
    localparam int SCREEN_ROWS   = 256;
    localparam int WORDS_PER_ROW = 32;   // SCREEN_COLS / DATA_W

    // which target a cpu address lands on
    typedef enum logic [1:0] {
        CLS_NONE,
        CLS_RAM,
        CLS_SCREEN,
        CLS_KBD
    } addr_class_t;

    // cpu port, load is the write strobe
    typedef struct packed {
        logic [CPU_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
        logic                  load;
    } cpu_req_t;

    // one access on the shared screen buffer port
    typedef struct packed {
        logic [SCREEN_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]        data;
        logic                     we;
    } screen_req_t;

    // pixel with its raster position
    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
        logic       value;
    } pixel_t;

endpackage

//--- logic/hack_memory_top.sv
`timescale 1ns/1ns

module hack_memory_top (
    input  logic                   clk,
    input  logic                   reset,
    input  hack_mem_pkg::cpu_req_t cpu,
    input  logic [7:0]             keyboard,
    output logic [15:0]            out,
    output hack_mem_pkg::pixel_t   pixel,
    output logic                   pixel_valid
);

    logic [13:0]               ram_addr;
    logic [15:0]               ram_d;
    logic                      ram_we;
    logic [15:0]               ram_q;
    hack_mem_pkg::screen_req_t cpu_screen;
    logic                      cpu_screen_sel;
    hack_mem_pkg::screen_req_t mem_req;   // winner on the screen port
    logic [15:0]               screen_q;  // shared by cpu and scanner
    logic [12:0]               scan_addr;
    logic                      scan_req;
    logic                      scan_grant;

    memory_map i_memory_map (
        .clk            (clk),
        .reset          (reset),
        .cpu            (cpu),
        .keyboard       (keyboard),
        .ram_addr       (ram_addr),
        .ram_d          (ram_d),
        .ram_we         (ram_we),
        .ram_q          (ram_q),
        .cpu_screen     (cpu_screen),
        .cpu_screen_sel (cpu_screen_sel),
        .screen_q       (screen_q),
        .out            (out)
    );

    word_ram #(.DEPTH(hack_mem_pkg::RAM_WORDS)) i_data_ram (
        .clk  (clk),
        .addr (ram_addr),
        .d    (ram_d),
        .we   (ram_we),
        .q    (ram_q)
    );

    word_ram #(.DEPTH(hack_mem_pkg::SCREEN_WORDS)) i_screen_ram (
        .clk  (clk),
        .addr (mem_req.addr),
        .d    (mem_req.data),
        .we   (mem_req.we),
        .q    (screen_q)
    );

    screen_arbiter i_screen_arbiter (
        .clk            (clk),
        .reset          (reset),
        .cpu_screen     (cpu_screen),
        .cpu_screen_sel (cpu_screen_sel),
        .scan_addr      (scan_addr),
        .scan_req       (scan_req),
        .scan_grant     (scan_grant),
        .mem_req        (mem_req)
    );

    video_scanner i_video_scanner (
        .clk         (clk),
        .reset       (reset),
        .scan_addr   (scan_addr),
        .scan_req    (scan_req),
        .scan_grant  (scan_grant),
        .screen_q    (screen_q),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

endmodule

//--- logic/memory_map.sv
`timescale 1ns/1ns

module memory_map (
    input  logic                      clk,
    input  logic                      reset,
    input  hack_mem_pkg::cpu_req_t    cpu,
    input  logic [7:0]                keyboard,

    // data ram port
    output logic [13:0]               ram_addr,
    output logic [15:0]               ram_d,
    output logic                      ram_we,
    input  logic [15:0]               ram_q,

    // screen buffer request, goes through the arbiter
    output hack_mem_pkg::screen_req_t cpu_screen,
    output logic                      cpu_screen_sel,
    input  logic [15:0]               screen_q,

    output logic [15:0]               out
);

    hack_mem_pkg::addr_class_t cls;     // class of the current address
    hack_mem_pkg::addr_class_t cls_q;   // class of last cycle's address
    logic [7:0]                kbd_q;

    // screen range ends after word 24575, the bound is exclusive
    always_comb begin
        if (cpu.addr < 15'(hack_mem_pkg::RAM_WORDS)) begin
            cls = hack_mem_pkg::CLS_RAM;
        end else if (cpu.addr < 15'(hack_mem_pkg::SCREEN_BASE + hack_mem_pkg::SCREEN_WORDS)) begin
            cls = hack_mem_pkg::CLS_SCREEN;
        end else if (cpu.addr == 15'(hack_mem_pkg::KBD_ADDR)) begin
            cls = hack_mem_pkg::CLS_KBD;
        end else begin
            cls = hack_mem_pkg::CLS_NONE;   // unmapped, reads zero
        end
    end

    // data ram sees the low address bits every cycle
    assign ram_addr = cpu.addr[13:0];
    assign ram_d    = cpu.data;
    assign ram_we   = cpu.load && (cls == hack_mem_pkg::CLS_RAM);

    // screen offset relative to the buffer base
    always_comb begin
        cpu_screen.addr = 13'(cpu.addr - 15'(hack_mem_pkg::SCREEN_BASE));
        cpu_screen.data = cpu.data;
        cpu_screen.we   = cpu.load && (cls == hack_mem_pkg::CLS_SCREEN);
    end

    // reads need the port as well, so select on class alone
    assign cpu_screen_sel = (cls == hack_mem_pkg::CLS_SCREEN);

    // class travels one cycle, in step with the ram read
    always_ff @(posedge clk) begin
        if (reset) begin
            cls_q <= hack_mem_pkg::CLS_NONE;
        end else begin
            cls_q <= cls;
        end
    end

    always_ff @(posedge clk) begin
        kbd_q <= keyboard;   // sampled with the address
    end

    // read data return
    always_comb begin
        case (cls_q)
            hack_mem_pkg::CLS_RAM:    out = ram_q;
            hack_mem_pkg::CLS_SCREEN: out = screen_q;
            hack_mem_pkg::CLS_KBD:    out = {8'd0, kbd_q};   // zero-extended code
            default:                  out = 16'd0;
        endcase
    end

endmodule

//--- logic/screen_arbiter.sv
`timescale 1ns/1ns

module screen_arbiter (
    input  logic                      clk,
    input  logic                      reset,

    // cpu side, always wins
    input  hack_mem_pkg::screen_req_t cpu_screen,
    input  logic                      cpu_screen_sel,

    // scanner side, read only
    input  logic [12:0]               scan_addr,
    input  logic                      scan_req,
    output logic                      scan_grant,

    // to the screen ram
    output hack_mem_pkg::screen_req_t mem_req
);

    logic scan_win;   // scanner owns the port this cycle

    // no second win while the grant for the first is still showing,
    // the scanner only drops its request after it has seen the grant
    assign scan_win = scan_req && !cpu_screen_sel && !scan_grant;

    always_comb begin
        if (cpu_screen_sel) begin
            mem_req = cpu_screen;
        end else begin
            mem_req.addr = scan_addr;   // idle cycles just do a harmless read
            mem_req.data = 16'd0;
            mem_req.we   = 1'b0;
        end
    end

    // grant rises with the ram's registered q for the scanner address
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_grant <= 1'b0;
        end else begin
            scan_grant <= scan_win;
        end
    end

endmodule

//--- logic/video_scanner.sv
`timescale 1ns/1ns

module video_scanner (
    input  logic                 clk,
    input  logic                 reset,

    output logic [12:0]          scan_addr,
    output logic                 scan_req,
    input  logic                 scan_grant,
    input  logic [15:0]          screen_q,

    output hack_mem_pkg::pixel_t pixel,
    output logic                 pixel_valid
);

    logic [12:0] word_cnt;    // next word to fetch
    logic [15:0] nxt_word;    // prefetched word waiting
    logic        nxt_valid;
    logic [15:0] shift_reg;
    logic [4:0]  bit_cnt;     // bits left in shift_reg, 0 to 16
    logic [8:0]  x_cnt;
    logic [7:0]  y_cnt;
    logic        consume;     // a pixel leaves this cycle
    logic        load_shift;  // refill from nxt_word

    assign scan_addr   = word_cnt;
    assign pixel_valid = (bit_cnt != 5'd0);
    assign consume     = pixel_valid;
    assign load_shift  = nxt_valid && (bit_cnt <= 5'd1);   // no gap if the word is ready

    assign pixel.x     = x_cnt;
    assign pixel.y     = y_cnt;
    assign pixel.value = shift_reg[0];   // lsb is the leftmost pixel

    // fetch side
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_req  <= 1'b0;
            nxt_valid <= 1'b0;
            word_cnt  <= 13'd0;
        end else begin
            if (load_shift) begin
                nxt_valid <= 1'b0;
            end
            if (scan_grant) begin
                scan_req  <= 1'b0;
                nxt_valid <= 1'b1;
                if (word_cnt == 13'(hack_mem_pkg::SCREEN_WORDS - 1)) begin
                    word_cnt <= 13'd0;   // back to the top of the frame
                end else begin
                    word_cnt <= word_cnt + 13'd1;
                end
            end else if (!scan_req && !nxt_valid && (bit_cnt <= 5'd8)) begin
                scan_req <= 1'b1;        // prefetch with half a word left
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_grant) begin
            nxt_word <= screen_q;   // q lines up with the grant
        end
    end

    // shift side
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt <= 5'd0;
        end else if (load_shift) begin
            bit_cnt <= 5'd16;
        end else if (consume) begin
            bit_cnt <= bit_cnt - 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_shift) begin
            shift_reg <= nxt_word;
        end else if (consume) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    // raster position of the pixel on the output
    always_ff @(posedge clk) begin
        if (reset) begin
            x_cnt <= 9'd0;
            y_cnt <= 8'd0;
        end else if (consume) begin
            if (x_cnt == 9'(hack_mem_pkg::SCREEN_COLS - 1)) begin
                x_cnt <= 9'd0;
                if (y_cnt == 8'(hack_mem_pkg::SCREEN_ROWS - 1)) begin
                    y_cnt <= 8'd0;
                end else begin
                    y_cnt <= y_cnt + 8'd1;
                end
            end else begin
                x_cnt <= x_cnt + 9'd1;
            end
        end
    end

endmodule

//--- logic/word_ram.sv
`timescale 1ns/1ns

module word_ram #(
    parameter int DEPTH = 16384
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [15:0]              d,
    input  logic                     we,
    output logic [15:0]              q
);

    logic [15:0] mem [DEPTH];

    // q shows the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= d;
        end
        q <= mem[addr];   // registered read
    end

endmodule

//--- sim/hack_memory_assert.sv
`timescale 1ns/1ns

module hack_memory_assert (
    input logic clk,
    input logic reset,
    input logic cpu_screen_sel,
    input logic scan_req,
    input logic scan_grant
);

    int unsigned fail_count = 0;

    // cpu owns the port, so no scanner data comes back next cycle
    cpu_blocks_grant: assert property (@(posedge clk) disable iff (reset)
        cpu_screen_sel |=> !scan_grant)
        else begin
            $error("scan_grant high in the cycle after a cpu screen access");
            fail_count++;
        end

    grant_needs_request: assert property (@(posedge clk) disable iff (reset)
        scan_grant |-> $past(scan_req))
        else begin
            $error("scan_grant without a scanner request in the cycle before");
            fail_count++;
        end

    grant_low_in_reset: assert property (@(posedge clk) reset |=> !scan_grant)
        else begin
            $error("scan_grant high while reset is applied");
            fail_count++;
        end

endmodule

bind screen_arbiter hack_memory_assert i_hack_memory_assert (
    .clk            (clk),
    .reset          (reset),
    .cpu_screen_sel (cpu_screen_sel),
    .scan_req       (scan_req),
    .scan_grant     (scan_grant)
);

//--- sim/tb_hack_memory.sv
`timescale 1ns/1ns

module tb_hack_memory;

    localparam int FRAME_PIXELS = hack_mem_pkg::SCREEN_COLS * hack_mem_pkg::SCREEN_ROWS;
    localparam int WAIT_LIMIT   = 400000;   // cycles, two frames plus stalls

    logic                   clk;
    logic                   reset;
    hack_mem_pkg::cpu_req_t cpu;
    logic [7:0]             keyboard;
    logic [15:0]            out;
    hack_mem_pkg::pixel_t   pixel;
    logic                   pixel_valid;

    logic [15:0] ram_model [hack_mem_pkg::RAM_WORDS];
    logic [15:0] scr_model [hack_mem_pkg::SCREEN_WORDS];
    logic [31:0] lcg_state = 32'h7d05_7f08;
    logic [14:0] addr_list [64];

    // read in flight, then the read whose data is on out
    logic        pend_valid;
    logic [15:0] pend_exp;
    string       pend_name;
    logic        chk_valid;
    logic [15:0] chk_exp;
    string       chk_name;

    logic        frame_armed;
    int          frames_req;
    logic        in_frame;
    int          frames_done;
    int          pix_cnt;
    logic [8:0]  exp_x;
    logic [7:0]  exp_y;

    int read_errors;
    int pixel_errors;
    int timeout_errors;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    hack_memory_top i_hack_memory_top (
        .clk         (clk),
        .reset       (reset),
        .cpu         (cpu),
        .keyboard    (keyboard),
        .out         (out),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected out for a cpu read, from the address map
    function automatic logic [15:0] expected_read(logic [14:0] addr);
        if (int'(addr) < hack_mem_pkg::RAM_WORDS) begin
            return ram_model[addr[13:0]];
        end else if (int'(addr) < hack_mem_pkg::SCREEN_BASE + hack_mem_pkg::SCREEN_WORDS) begin
            return scr_model[13'(int'(addr) - hack_mem_pkg::SCREEN_BASE)];
        end else if (int'(addr) == hack_mem_pkg::KBD_ADDR) begin
            return {8'd0, keyboard};
        end
        return 16'd0;
    endfunction

    function automatic logic expected_pixel(logic [8:0] x, logic [7:0] y);
        logic [15:0] word;
        word = scr_model[13'(int'(y) * hack_mem_pkg::WORDS_PER_ROW + int'(x) / 16)];
        return word[4'(int'(x) % 16)];   // bit 0 is leftmost
    endfunction

    function automatic logic [15:0] fill_pattern(logic [12:0] a);
        return 16'(32'(a) * 32'h9e37) ^ {a, 3'b101};
    endfunction

    task automatic cpu_write(logic [14:0] addr, logic [15:0] data);
        @(negedge clk);
        cpu.addr   = addr;
        cpu.data   = data;
        cpu.load   = 1'b1;
        pend_valid = 1'b0;
        if (int'(addr) < hack_mem_pkg::RAM_WORDS) begin
            ram_model[addr[13:0]] = data;
        end else if (int'(addr) < hack_mem_pkg::SCREEN_BASE + hack_mem_pkg::SCREEN_WORDS) begin
            scr_model[13'(int'(addr) - hack_mem_pkg::SCREEN_BASE)] = data;
        end   // keyboard and unmapped writes go nowhere
    endtask

    task automatic cpu_read(logic [14:0] addr, string name);
        @(negedge clk);
        cpu.addr   = addr;
        cpu.data   = 16'(lcg_next());   // noise, load is low
        cpu.load   = 1'b0;
        pend_exp   = expected_read(addr);
        pend_name  = name;
        pend_valid = 1'b1;
    endtask

    task automatic cpu_idle();
        @(negedge clk);
        cpu.addr   = 15'h7fff;   // unmapped, leaves the screen port to the scanner
        cpu.load   = 1'b0;
        pend_valid = 1'b0;
    endtask

    task automatic report_and_finish();
        int asserts;
        asserts = i_hack_memory_top.i_screen_arbiter.i_hack_memory_assert.fail_count;
        $display("errors: read %0d, pixel %0d, arbiter %0d, timeout %0d",
                 read_errors, pixel_errors, asserts, timeout_errors);
        if (read_errors + pixel_errors + asserts + timeout_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        timeout_errors++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic wait_for_row(logic [7:0] row);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (pixel_valid && pixel.y == row) break;
        end
        if (n == WAIT_LIMIT) report_timeout("a pixel of the requested row");
    endtask

    task automatic wait_for_frames(int count);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);   // frame counter settles on the falling edge
            if (frames_done >= count) break;
        end
        if (n == WAIT_LIMIT) report_timeout("a complete checked frame");
    endtask

    // out belongs to the read issued one cycle earlier
    always @(posedge clk) begin
        if (reset) begin
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= pend_valid;
            chk_exp   <= pend_exp;
            chk_name  <= pend_name;
        end
    end

    always @(negedge clk) begin
        if (chk_valid) begin
            assert (out === chk_exp) else begin
                read_errors++;
                $display("Fail %s: expected %h, actual %h", chk_name, chk_exp, out);
            end
        end
    end

    // raster order and pixel values, from a frame start on
    always @(negedge clk) begin
        if (reset) begin
            in_frame    = 1'b0;
            frames_done = 0;
            pix_cnt     = 0;
        end else if (pixel_valid) begin
            if (!in_frame && frame_armed && frames_done < frames_req
                    && pixel.x == 9'd0 && pixel.y == 8'd0) begin
                in_frame = 1'b1;
                exp_x    = 9'd0;
                exp_y    = 8'd0;
            end
            if (in_frame) begin
                assert (pixel.x == exp_x && pixel.y == exp_y) else begin
                    pixel_errors++;
                    $display("Fail pixel_order: expected (%0d,%0d), actual (%0d,%0d)",
                             exp_x, exp_y, pixel.x, pixel.y);
                end
                assert (pixel.value === expected_pixel(pixel.x, pixel.y)) else begin
                    pixel_errors++;
                    $display("Fail pixel_value at (%0d,%0d): expected %b, actual %b",
                             pixel.x, pixel.y, expected_pixel(pixel.x, pixel.y), pixel.value);
                end
                if (exp_x == 9'(hack_mem_pkg::SCREEN_COLS - 1)) begin
                    exp_x = 9'd0;
                    exp_y = exp_y + 8'd1;   // wraps after the last row
                end else begin
                    exp_x = exp_x + 9'd1;
                end
                pix_cnt++;
                if (pix_cnt == FRAME_PIXELS) begin
                    pix_cnt = 0;
                    frames_done++;
                    if (frames_done >= frames_req) in_frame = 1'b0;
                end
            end
        end
    end

    initial begin
        logic [12:0] off;
        logic [14:0] unmapped_addr;
        reset          = 1'b1;
        cpu            = '{addr: 15'h7fff, data: 16'd0, load: 1'b0};
        keyboard       = 8'h00;
        pend_valid     = 1'b0;
        frame_armed    = 1'b0;
        frames_req     = 0;
        read_errors    = 0;
        pixel_errors   = 0;
        timeout_errors = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // data ram: clear, write half, read all
        for (int i = 0; i < 64; i++) begin
            addr_list[i] = {1'b0, 14'(lcg_next() >> 8)};
            cpu_write(addr_list[i], 16'd0);
        end
        for (int i = 0; i < 32; i++) cpu_write(addr_list[i], 16'(lcg_next() >> 16));
        for (int i = 0; i < 64; i++) cpu_read(addr_list[i], "ram_random");
        for (int i = 0; i < 16; i++) begin
            cpu_write(addr_list[i], 16'(lcg_next() >> 12));
            cpu_read(addr_list[i], "ram_write_then_read");
        end
        cpu_idle();

        // screen words against data ram words with equal low bits
        for (int i = 0; i < 16; i++) begin
            off = (i == 0) ? 13'd8191 : (i == 1) ? 13'd0 : 13'(lcg_next() >> 9);
            cpu_write({2'b00, off}, 16'(lcg_next() >> 16));
            cpu_write(15'(hack_mem_pkg::SCREEN_BASE + int'(off)), 16'(lcg_next() >> 8));
            cpu_read(15'(hack_mem_pkg::SCREEN_BASE + int'(off)), "screen_readback");
            cpu_read({2'b00, off}, "ram_under_screen");
        end
        cpu_idle();

        // keyboard and the unmapped top of the space
        cpu_write(15'(hack_mem_pkg::KBD_ADDR % hack_mem_pkg::RAM_WORDS), 16'(lcg_next() >> 4));
        for (int i = 0; i < 4; i++) begin
            cpu_idle();
            keyboard = 8'(lcg_next() >> 24);
            cpu_read(15'(hack_mem_pkg::KBD_ADDR), "kbd_read");
            cpu_write(15'(hack_mem_pkg::KBD_ADDR), 16'hffff);
            cpu_read(15'(hack_mem_pkg::KBD_ADDR), "kbd_after_write");
        end
        // words a keyboard write would hit if it leaked into ram or screen
        cpu_read(15'(hack_mem_pkg::KBD_ADDR % hack_mem_pkg::RAM_WORDS), "kbd_write_ram_alias");
        cpu_read(15'(hack_mem_pkg::SCREEN_BASE), "kbd_write_screen_alias");
        for (int i = 0; i < 10; i++) begin
            unmapped_addr = (i == 0) ? 15'd24577 : (i == 1) ? 15'h7fff
                          : 15'(hack_mem_pkg::KBD_ADDR + 1 + int'(lcg_next() >> 20));
            cpu_write(unmapped_addr, 16'(lcg_next()));
            cpu_read(unmapped_addr, "unmapped_read");
        end
        cpu_idle();

        // full screen pattern, then two frames with traffic in the second
        for (int a = 0; a < hack_mem_pkg::SCREEN_WORDS; a++) begin
            cpu_write(15'(hack_mem_pkg::SCREEN_BASE + a), fill_pattern(13'(a)));
        end
        cpu_idle();
        wait_for_row(8'd1);   // every later fetch sees the filled buffer
        if (timeout_errors == 0) begin
            frames_req  = 2;
            frame_armed = 1'b1;
            wait_for_frames(1);
        end
        if (timeout_errors == 0) begin
            for (int burst = 0; burst < 8; burst++) begin
                for (int i = 0; i < 100; i++) begin
                    off = 13'(lcg_next() >> 9);
                    if (i % 4 == 3) begin
                        cpu_write(15'(hack_mem_pkg::SCREEN_BASE + int'(off)), scr_model[off]);
                    end else begin
                        cpu_read(15'(hack_mem_pkg::SCREEN_BASE + int'(off)), "screen_traffic");
                    end
                end
                cpu_read(addr_list[burst], "read_during_scan");
                for (int i = 0; i < 200; i++) cpu_idle();
            end
            wait_for_frames(2);
        end
        report_and_finish();
    end

endmodule
